// ==== project.f ====
+incdir+verification
source/activation_pkg.sv
source/gain_multiplier.sv
source/sigmoid.sv
source/activation_output.sv
source/activation_top.sv
verification/activation_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the activation testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module activation_tb -f project.f -Mdir obj_dir
status=0
./obj_dir/Vactivation_tb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q '\*\* FAIL \*\*' sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// ==== source/activation_output.sv ====
// Activation output stage
// Registers the activation word, its valid strobe and the half flag

module activation_output import activation_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        scaled_valid,
  input  float_word_u activation,
  output logic        out_valid,
  output float_word_u out_data,
  output logic        above_half
);

  // Flag from the word being loaded
  logic half_next;

  // Exponent 126 or more means at least 0.5
  assign half_next = (activation.fields.exp >= 8'd126);

  // ----------------------------------------
  // Output registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid   <= 1'b0;
      out_data    <= '0;
      above_half  <= 1'b0;
    end else begin
      // Strobe follows every cycle
      out_valid <= scaled_valid;
      // Data and flag hold between samples
      if (scaled_valid) begin
        out_data.bits <= activation.bits;
        above_half    <= half_next;
      end
    end
  end

  // Every result traces back to a scaled sample
  assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> $past(scaled_valid))
    else $error("activation_output: out_valid without scaled_valid");

endmodule

// ==== source/activation_pkg.sv ====
// Activation package
// Float word layout, union views and exponent and gain constants

package activation_pkg;

  // ----------------------------------------
  // Float layout
  // ----------------------------------------

  // 1 sign, 8 exponent, 23 mantissa bits
  typedef struct packed {
    logic        sgn;
    logic [7:0]  exp;
    logic [22:0] man;
  } float_24_8;

  // One 32-bit word, seen as fields or as raw bits
  typedef union packed {
    // Arithmetic and segment decode
    float_24_8   fields;
    // Ports, zero test, register loads
    logic [31:0] bits;
  } float_word_u;

  // ----------------------------------------
  // Constants
  // ----------------------------------------

  // Exponent bias
  localparam logic [7:0]  EXP_BIAS = 8'd127;

  // Largest normal exponent
  localparam logic [7:0]  EXP_MAX  = 8'd254;

  // 1.0, gain after reset
  localparam logic [31:0] GAIN_ONE = {1'b0, 8'd127, 23'd0};

endpackage

// ==== source/activation_top.sv ====
// Activation top level
// Gain multiply, sigmoid and output register for one neuron

module activation_top import activation_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        gain_load,
  input  logic [31:0] gain_value,
  input  logic        in_valid,
  input  logic [31:0] in_data,
  output logic        out_valid,
  output logic [31:0] out_data,
  output logic        above_half
);

  // Raw words mapped onto the union
  float_word_u gain_word;
  float_word_u in_word;
  float_word_u out_word;

  // Stage links
  logic        scaled_valid;
  float_word_u scaled;
  float_word_u activation;

  assign gain_word.bits = gain_value;
  assign in_word.bits   = in_data;
  assign out_data       = out_word.bits;

  // ----------------------------------------
  // Stages
  // ----------------------------------------

  // Cycle 1, gain scaling
  gain_multiplier i_gain_multiplier (
    .clk          (clk),
    .arst_n       (arst_n),
    .gain_load    (gain_load),
    .gain_value   (gain_word),
    .in_valid     (in_valid),
    .in_data      (in_word),
    .scaled_valid (scaled_valid),
    .scaled       (scaled)
  );

  // Same cycle, no register
  sigmoid i_sigmoid (
    .scaled     (scaled),
    .activation (activation)
  );

  // Cycle 2, result register
  activation_output i_activation_output (
    .clk          (clk),
    .arst_n       (arst_n),
    .scaled_valid (scaled_valid),
    .activation   (activation),
    .out_valid    (out_valid),
    .out_data     (out_word),
    .above_half   (above_half)
  );

endmodule

// ==== source/gain_multiplier.sv ====
// Gain multiplier
// Holds the programmable gain and scales each input sample by it,
// truncating float multiply with one register stage

module gain_multiplier import activation_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        gain_load,
  input  float_word_u gain_value,
  input  logic        in_valid,
  input  float_word_u in_data,
  output logic        scaled_valid,
  output float_word_u scaled
);

  // Gain register
  float_word_u        gain_q;

  // Multiplier datapath
  logic               zero_operand;
  logic               prod_sgn;
  logic [47:0]        mant_prod;
  logic [22:0]        mant_norm;
  logic signed [9:0]  exp_sum;
  float_word_u        product;

  // ----------------------------------------
  // Gain register
  // ----------------------------------------

  // New gain applies from the next sample on
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gain_q.bits <= GAIN_ONE;
    end else if (gain_load) begin
      gain_q.bits <= gain_value.bits;
    end
  end

  // ----------------------------------------
  // Float multiply
  // ----------------------------------------

  // Zero exponent on either side flushes to zero
  assign zero_operand = (in_data.bits[30:23] == 8'd0) || (gain_q.bits[30:23] == 8'd0);

  assign prod_sgn = in_data.fields.sgn ^ gain_q.fields.sgn;

  // Mantissas with hidden one, 24 x 24
  assign mant_prod = 48'({1'b1, in_data.fields.man}) * 48'({1'b1, gain_q.fields.man});

  // Product in [1,4), normalize by one place at most
  assign mant_norm = mant_prod[47] ? mant_prod[46:24] : mant_prod[45:23];

  // Biased sum, plus one when normalized
  assign exp_sum = $signed({2'b00, in_data.fields.exp})
                 + $signed({2'b00, gain_q.fields.exp})
                 - $signed({2'b00, EXP_BIAS})
                 + $signed({9'd0, mant_prod[47]});

  always_comb begin
    product.bits = '0;
    if (zero_operand || (exp_sum < 10'sd1)) begin
      // Zero operand or underflow
      product.bits = '0;
    end else if (exp_sum > $signed({2'b00, EXP_MAX})) begin
      // Overflow saturates to the largest normal
      product.fields.sgn = prod_sgn;
      product.fields.exp = EXP_MAX;
      product.fields.man = '1;
    end else begin
      product.fields.sgn = prod_sgn;
      product.fields.exp = exp_sum[7:0];
      product.fields.man = mant_norm;
    end
  end

  // ----------------------------------------
  // Pipeline register
  // ----------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      scaled_valid <= 1'b0;
    end else begin
      scaled_valid <= in_valid;
    end
  end

  // Payload only moves with a valid sample
  always_ff @(posedge clk) begin
    if (in_valid) begin
      scaled.bits <= product.bits;
    end
  end

  // Valid strobe must stay clean for the output stage
  assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(scaled_valid))
    else $error("gain_multiplier: scaled_valid unknown");

endmodule

// ==== source/sigmoid.sv ====
// Sigmoid
// Piecewise-linear sigmoid on float fields, purely combinational

module sigmoid import activation_pkg::*; (
  input  float_word_u scaled,
  output float_word_u activation
);

  // Input fields
  float_24_8 x;

  assign x = scaled.fields;

  // Result is never negative
  assign activation.fields.sgn = 1'b0;

  // ----------------------------------------
  // Exponent segment decode
  // ----------------------------------------
  always_comb begin
    activation.fields.exp = 8'd126;
    if (x.exp > 8'd129) begin
      // Saturated tails
      activation.fields.exp = x.sgn ? 8'd0 : 8'd127;
    end else if (x.exp == 8'd129) begin
      if (!x.sgn) begin
        activation.fields.exp = 8'd126;
      end else if (!x.man[22]) begin
        activation.fields.exp = 8'd121;
      end else if (!x.man[21]) begin
        activation.fields.exp = 8'd120;
      end else if (!x.man[20]) begin
        activation.fields.exp = 8'd119;
      end else begin
        // Includes m[22:19] all ones
        activation.fields.exp = 8'd118;
      end
    end else if (x.exp == 8'd128) begin
      activation.fields.exp = x.sgn ? (x.man[22] ? 8'd122 : 8'd123) : 8'd126;
    end else if (x.exp == 8'd127) begin
      activation.fields.exp = x.sgn ? 8'd124 : 8'd126;
    end else begin
      // Small inputs sit around one half
      activation.fields.exp = x.sgn ? 8'd125 : 8'd126;
    end
  end

  // ----------------------------------------
  // Mantissa shift and invert
  // ----------------------------------------
  always_comb begin
    activation.fields.man = '0;
    if (x.exp > 8'd129) begin
      activation.fields.man = 23'd0;
    end else if (x.exp == 8'd129) begin
      // Negative side carries exponent only
      activation.fields.man = x.sgn ? 23'd0 : {4'he, x.man[22:4]};
    end else if (x.exp == 8'd128) begin
      activation.fields.man = x.sgn ? {~x.man[21:0], 1'b0} : {3'h6, x.man[22:3]};
    end else if (x.exp == 8'd127) begin
      activation.fields.man = x.sgn ? ~x.man : {2'h2, x.man[22:2]};
    end else if (x.exp == 8'd126) begin
      activation.fields.man = x.sgn ? {1'b0, ~x.man[22:1]} : {2'h1, x.man[22:2]};
    end else if (x.exp == 8'd125) begin
      activation.fields.man = x.sgn ? {2'h2, ~x.man[22:2]} : {3'h1, x.man[22:3]};
    end else if (x.exp == 8'd124) begin
      activation.fields.man = x.sgn ? {3'h6, ~x.man[22:3]} : {4'h1, x.man[22:4]};
    end else begin
      activation.fields.man = x.sgn ? {4'he, ~x.man[22:4]} : {5'h01, x.man[22:5]};
    end
  end

  // Result stays within [0, 1.0]
  always_comb begin
    if (!$isunknown(scaled.bits)) begin
      assert final ((activation.fields.exp < 8'd127) ||
                    ((activation.fields.exp == 8'd127) && (activation.fields.man == 23'd0)))
        else $error("sigmoid: activation above 1.0, %h", activation.bits);
    end
  end

endmodule

// ==== verification/activation_vectors.svh ====
// Activation test vectors
// Directed rows for the sigmoid segments and the gain multiplier

// Columns: name, gain_load, gain in effect, input word, expected out_data
typedef struct packed {
  logic [127:0] name;
  logic         load;
  logic [31:0]  gain;
  logic [31:0]  data;
  logic [31:0]  expected;
} vector_t;

localparam int NUM_VECTORS = 30;

vector_t vectors [NUM_VECTORS] = '{
  // Reset gain of 1.0 passes the input through
  '{"reset_gain",     1'b0, 32'h3f80_0000, 32'h3f00_0000, 32'h3f20_0000},
  // Saturated tails
  '{"sat_pos",        1'b0, 32'h3f80_0000, 32'h4120_0000, 32'h3f80_0000},
  '{"sat_neg",        1'b0, 32'h3f80_0000, 32'hc120_0000, 32'h0000_0000},
  // Exponent 129, negative side picks exponent by leading ones
  '{"e129_pos",       1'b0, 32'h3f80_0000, 32'h40a0_0000, 32'h3f72_0000},
  '{"e129_neg_m22",   1'b0, 32'h3f80_0000, 32'hc080_0000, 32'h3c80_0000},
  '{"e129_neg_m21",   1'b0, 32'h3f80_0000, 32'hc0c0_0000, 32'h3c00_0000},
  '{"e129_neg_m20",   1'b0, 32'h3f80_0000, 32'hc0e0_0000, 32'h3b80_0000},
  '{"e129_neg_m19",   1'b0, 32'h3f80_0000, 32'hc0f0_0000, 32'h3b00_0000},
  '{"e129_neg_ones",  1'b0, 32'h3f80_0000, 32'hc0ff_ffff, 32'h3b00_0000},
  // Exponents 128 down to below 124
  '{"e128_pos",       1'b0, 32'h3f80_0000, 32'h4040_0000, 32'h3f68_0000},
  '{"e128_neg_hi",    1'b0, 32'h3f80_0000, 32'hc040_0000, 32'h3d7f_fffe},
  '{"e128_neg_lo",    1'b0, 32'h3f80_0000, 32'hc010_0000, 32'h3ddf_fffe},
  '{"e127_pos",       1'b0, 32'h3f80_0000, 32'h3fc0_0000, 32'h3f50_0000},
  '{"e127_neg",       1'b0, 32'h3f80_0000, 32'hbfc0_0000, 32'h3e3f_ffff},
  '{"e126_neg",       1'b0, 32'h3f80_0000, 32'hbf40_0000, 32'h3e9f_ffff},
  '{"e125_pos",       1'b0, 32'h3f80_0000, 32'h3e80_0000, 32'h3f10_0000},
  '{"e125_neg",       1'b0, 32'h3f80_0000, 32'hbea0_0000, 32'h3ed7_ffff},
  '{"e124_pos",       1'b0, 32'h3f80_0000, 32'h3e40_0000, 32'h3f0c_0000},
  '{"e124_neg",       1'b0, 32'h3f80_0000, 32'hbe00_0000, 32'h3eef_ffff},
  '{"small_pos",      1'b0, 32'h3f80_0000, 32'h3d80_0000, 32'h3f04_0000},
  '{"small_neg",      1'b0, 32'h3f80_0000, 32'hbd80_0000, 32'h3ef7_ffff},
  // Gain loads, each on the edge of the row before
  '{"gain_two",       1'b1, 32'h4000_0000, 32'h3f80_0000, 32'h3f60_0000},
  '{"gain_half",      1'b1, 32'h3f00_0000, 32'hc000_0000, 32'h3e7f_ffff},
  '{"gain_1p5",       1'b1, 32'h3fc0_0000, 32'h3fc0_0000, 32'h3f62_0000},
  '{"gain_1p5_neg",   1'b0, 32'h3fc0_0000, 32'hbf40_0000, 32'h3e6f_ffff},
  '{"zero_input",     1'b0, 32'h3fc0_0000, 32'h0000_0000, 32'h3f04_0000},
  '{"zero_gain",      1'b1, 32'h0000_0000, 32'h3f80_0000, 32'h3f04_0000},
  '{"underflow",      1'b1, 32'h0080_0000, 32'hbe80_0000, 32'h3f04_0000},
  '{"overflow_neg",   1'b1, 32'h7f00_0000, 32'hc000_0000, 32'h0000_0000},
  '{"overflow_pos",   1'b0, 32'h7f00_0000, 32'h4000_0000, 32'h3f80_0000}
};

// ==== verification/activation_tb.sv ====
// Activation testbench
// Directed table and random samples, checked against a model of the rules

module activation_tb;

  localparam int          RANDOM_COUNT  = 200;
  localparam int          TIMEOUT_SLACK = 20;
  localparam logic [31:0] SEED          = 32'h6a96_8be8;

  logic         clk;
  logic         arst_n;
  logic         gain_load;
  logic [31:0]  gain_value;
  logic         in_valid;
  logic [31:0]  in_data;
  logic         out_valid;
  logic [31:0]  out_data;
  logic         above_half;

  // Results in flight, oldest first
  logic [31:0]  exp_q[$];
  logic [127:0] name_q[$];
  int           sent_q[$];

  int           errors = 0;
  int           cycle_count = 0;
  logic [31:0]  rand_state;
  logic [31:0]  cur_gain;
  logic [31:0]  exp_word;
  logic [127:0] exp_name;
  int           sent_cycle;

  `include "activation_vectors.svh"

  activation_top i_activation_top (.*);

  always #4 clk = ~clk;

  // LCG step
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Truncating float multiply with zero flush and saturation
  function automatic logic [31:0] float_mul(input logic [31:0] a, input logic [31:0] b);
    logic [47:0] p;
    int          e;
    if ((a[30:23] == 8'd0) || (b[30:23] == 8'd0)) return 32'd0;
    p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
    e = int'(a[30:23]) + int'(b[30:23]) - 127;
    // Product of two [1,2) values may reach [2,4)
    if (p[47]) begin
      p = p >> 1;
      e = e + 1;
    end
    if (e < 1) return 32'd0;
    if (e > 254) return {a[31] ^ b[31], 8'd254, 23'h7f_ffff};
    return {a[31] ^ b[31], e[7:0], p[45:23]};
  endfunction

  // Piecewise-linear sigmoid, one segment per input exponent
  function automatic logic [31:0] sigmoid_ref(input logic [31:0] x);
    logic [22:0] m;
    logic [22:0] n;
    logic [22:0] man;
    int          k;
    m = x[22:0];
    n = ~x[22:0];
    k = 0;
    if (x[30:23] > 8'd129) return x[31] ? 32'd0 : 32'h3f80_0000;
    if (!x[31]) begin
      // Upper half, fixed exponent 126
      case (x[30:23])
        8'd129:  man = 23'h70_0000 | (m >> 4);
        8'd128:  man = 23'h60_0000 | (m >> 3);
        8'd127:  man = 23'h40_0000 | (m >> 2);
        8'd126:  man = 23'h20_0000 | (m >> 2);
        8'd125:  man = 23'h10_0000 | (m >> 3);
        8'd124:  man = 23'h08_0000 | (m >> 4);
        default: man = 23'h04_0000 | (m >> 5);
      endcase
      return {1'b0, 8'd126, man};
    end
    // Lower half, inverted mantissa
    case (x[30:23])
      8'd129: begin
        // One exponent step per leading one, at most three
        while ((k < 3) && m[22 - k]) k = k + 1;
        return {1'b0, 8'(121 - k), 23'd0};
      end
      8'd128:  return {1'b0, m[22] ? 8'd122 : 8'd123, n[21:0], 1'b0};
      8'd127:  return {1'b0, 8'd124, n};
      8'd126:  return {1'b0, 8'd125, n >> 1};
      8'd125:  return {1'b0, 8'd125, 23'h40_0000 | (n >> 2)};
      8'd124:  return {1'b0, 8'd125, 23'h60_0000 | (n >> 3)};
      default: return {1'b0, 8'd125, 23'h70_0000 | (n >> 4)};
    endcase
  endfunction

  // Drive one sample and queue its result
  task automatic send_sample(input logic [127:0] name, input logic [31:0] data,
                             input logic [31:0] expected);
    in_valid = 1'b1;
    in_data  = data;
    exp_q.push_back(expected);
    name_q.push_back(name);
    sent_q.push_back(cycle_count);
  endtask

  // ----------------------------------------
  // Cycle counter and timeout
  // ----------------------------------------
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > NUM_VECTORS + RANDOM_COUNT + TIMEOUT_SLACK) begin
      $display("Timeout after %0d cycles with results still missing", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  // ----------------------------------------
  // Result monitor, outputs stable here
  // ----------------------------------------
  always @(negedge clk) begin
    if (arst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid was high with no sample in flight");
        errors++;
      end else begin
        exp_word   = exp_q.pop_front();
        exp_name   = name_q.pop_front();
        sent_cycle = sent_q.pop_front();
        // Half flag from the expected exponent
        assert ({above_half, out_data} == {exp_word[30:23] >= 8'd126, exp_word}) else begin
          $display("Error %0s: expected %h half %b, actual %h half %b", exp_name, exp_word,
                   exp_word[30:23] >= 8'd126, out_data, above_half);
          errors++;
        end
        assert (cycle_count - sent_cycle == 2) else begin
          $display("Result for %0s came %0d cycles after its sample instead of 2",
                   exp_name, cycle_count - sent_cycle);
          errors++;
        end
      end
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    gain_load  = 1'b0;
    gain_value = 32'd0;
    in_valid   = 1'b0;
    in_data    = 32'd0;
    rand_state = SEED;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    assert ({out_valid, above_half, out_data} == 34'd0) else begin
      $display("Error reset_state: expected %h, actual %h", 34'd0,
               {out_valid, above_half, out_data});
      errors++;
    end

    // Back to back, next row's gain loads behind the current sample
    foreach (vectors[i]) begin
      send_sample(vectors[i].name, vectors[i].data, vectors[i].expected);
      gain_load  = (i + 1 < NUM_VECTORS) ? vectors[(i + 1) % NUM_VECTORS].load : 1'b0;
      gain_value = vectors[(i + 1) % NUM_VECTORS].gain;
      @(negedge clk);
    end
    cur_gain = vectors[NUM_VECTORS - 1].gain;

    // Random gains and inputs, idle cycles in between
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      rand_state = lcg_next(rand_state);
      gain_load  = (rand_state[31:29] == 3'd0);
      in_valid   = (rand_state[28:27] != 2'd0);
      gain_value = {rand_state[26], 8'd123 + {5'd0, rand_state[25:23]}, rand_state[22:0]};
      rand_state = lcg_next(rand_state);
      in_data    = {rand_state[31], 8'd118 + {4'd0, rand_state[30:27]}, rand_state[22:0]};
      if (in_valid) send_sample("random", in_data, sigmoid_ref(float_mul(in_data, cur_gain)));
      // Sample on this edge still sees the old gain
      if (gain_load) cur_gain = gain_value;
      @(negedge clk);
    end

    in_valid  = 1'b0;
    gain_load = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    // One more cycle to catch a stray out_valid
    @(negedge clk);
    #1;
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
